//--- logic/board_pkg.sv
// ========================================
// Front-panel constants and types
// Keys are active low on the board
// Segment patterns are active low, bit 0 is segment a
// ========================================
`default_nettype none

package board_pkg;

  // Key map
  localparam int unsigned NUM_KEYS  = 4;
  localparam int unsigned KEY_GO    = 0;
  localparam int unsigned KEY_CLEAR = 1;
  localparam int unsigned KEY_RESET = 3;

  // Display types
  localparam int unsigned SEG_W = 7;

  typedef logic [SEG_W-1:0] seg_t;
  typedef logic [3:0]       bcd_t;

  // Digits 0 to 9, segments gfedcba
  localparam seg_t SEG_TABLE [0:9] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19,
    7'h12, 7'h02, 7'h78, 7'h00, 7'h10
  };

endpackage : board_pkg

`default_nettype wire

//--- logic/key_debouncer.sv
// ========================================
// Debouncer for one push button
// Input is asynchronous, released level is 1
// A new level is taken after DEBOUNCE_CYCLES stable cycles
// Pulses are one cycle, aligned with the change of out
// ========================================
`timescale 1ns/100ps
`default_nettype none

module key_debouncer #(
  parameter int unsigned DEBOUNCE_CYCLES = 1000
) (
  input  logic clk,
  input  logic rst,
  input  logic in,
  output logic out,
  output logic edj,
  output logic rise,
  output logic fall
);

  localparam int unsigned CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  logic             sync_meta;
  logic             sync;
  logic [CNT_W-1:0] stable_cnt;

  // ========================================
  // Two-flop synchronizer
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      sync_meta <= 1'b1;
      sync      <= 1'b1;
    end else begin
      sync_meta <= in;
      sync      <= sync_meta;
    end
  end

  // ========================================
  // Stability counter and accepted level
  // ========================================
  always_ff @(posedge clk) begin
    if (rst) begin
      stable_cnt <= '0;
      out        <= 1'b1;
      edj        <= 1'b0;
      rise       <= 1'b0;
      fall       <= 1'b0;
    end else begin
      edj  <= 1'b0;
      rise <= 1'b0;
      fall <= 1'b0;
      if (sync == out) begin
        // Input agrees with level, any bounce is forgotten
        stable_cnt <= '0;
      end else if (stable_cnt == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
        stable_cnt <= '0;
        out        <= sync;
        edj        <= 1'b1;
        rise       <= sync;
        fall       <= ~sync;
      end else begin
        stable_cnt <= stable_cnt + 1'b1;
      end
    end
  end

endmodule : key_debouncer

`default_nettype wire

//--- logic/reset_sequencer.sv
// ========================================
// System reset generation
// sys_rst is high while any cause is present
// and for RESET_HOLD cycles after the last one clears
// pll_locked is treated as asynchronous
// ========================================
`timescale 1ns/100ps
`default_nettype none

module reset_sequencer #(
  parameter int unsigned RESET_HOLD = 16
) (
  input  logic clk,
  input  logic rst,
  input  logic reset_key_n,
  input  logic pll_locked,
  output logic sys_rst
);

  localparam int unsigned CNT_W = $clog2(RESET_HOLD + 1);

  logic             lock_meta;
  logic             lock_sync;
  logic             reset_cause;
  logic [CNT_W-1:0] hold_cnt;

  // Lock flag into the clk domain
  always_ff @(posedge clk) begin
    if (rst) begin
      lock_meta <= 1'b0;
      lock_sync <= 1'b0;
    end else begin
      lock_meta <= pll_locked;
      lock_sync <= lock_meta;
    end
  end

  assign reset_cause = rst | ~reset_key_n | ~lock_sync;

  // Hold counter restarts on every cause
  always_ff @(posedge clk) begin
    if (reset_cause) begin
      hold_cnt <= '0;
      sys_rst  <= 1'b1;
    end else if (sys_rst) begin
      hold_cnt <= hold_cnt + 1'b1;
      if (hold_cnt == CNT_W'(RESET_HOLD - 1)) begin
        sys_rst <= 1'b0;
      end
    end
  end

endmodule : reset_sequencer

`default_nettype wire

//--- logic/run_counter.sv
// ========================================
// Decimal run counter
// One increment per go strobe, clear wins over go
// Wraps from all nines to zero
// ========================================
`timescale 1ns/100ps
`default_nettype none

module run_counter #(
  parameter int unsigned HEX_DIGITS = 6
) (
  input  logic                             clk,
  input  logic                             sys_rst,
  input  logic                             go,
  input  logic                             clear,
  output board_pkg::bcd_t [HEX_DIGITS-1:0] digits
);

  import board_pkg::*;

  bcd_t [HEX_DIGITS-1:0] digits_inc;
  // carry[i] is the carry into digit i
  logic [HEX_DIGITS:0]   carry;

  // ========================================
  // Carry chain for digits + 1
  // ========================================
  always_comb begin
    carry[0] = 1'b1;
    for (int i = 0; i < HEX_DIGITS; i++) begin
      if (!carry[i]) begin
        digits_inc[i] = digits[i];
        carry[i+1]    = 1'b0;
      end else if (digits[i] == bcd_t'(9)) begin
        digits_inc[i] = '0;
        carry[i+1]    = 1'b1;
      end else begin
        digits_inc[i] = digits[i] + 1'b1;
        carry[i+1]    = 1'b0;
      end
    end
  end

  // ========================================
  // Count register
  // ========================================
  always_ff @(posedge clk) begin
    if (sys_rst) begin
      digits <= '0;
    end else if (clear) begin
      digits <= '0;
    end else if (go) begin
      // Carry out of the top digit is dropped, giving the wrap
      digits <= digits_inc;
    end
  end

endmodule : run_counter

`default_nettype wire

//--- logic/hex_display.sv
// ========================================
// BCD to seven-segment decoder
// Outputs are active low
// Codes above 9 blank the digit
// ========================================
`timescale 1ns/100ps
`default_nettype none

module hex_display #(
  parameter int unsigned HEX_DIGITS = 6
) (
  input  board_pkg::bcd_t [HEX_DIGITS-1:0] digits,
  output board_pkg::seg_t [HEX_DIGITS-1:0] hex
);

  import board_pkg::*;

  always_comb begin
    for (int i = 0; i < HEX_DIGITS; i++) begin
      if (digits[i] <= bcd_t'(9)) begin
        hex[i] = SEG_TABLE[digits[i]];
      end else begin
        // All segments off
        hex[i] = '1;
      end
    end
  end

endmodule : hex_display

`default_nettype wire

//--- logic/front_panel_top.sv
// ========================================
// Front-panel control top level
// clk is the PLL output, pll_locked its lock flag
// Keys are active low, hex outputs active low
// led[0] is run, led[4:1] show pressed keys
// ========================================
`timescale 1ns/100ps
`default_nettype none

module front_panel_top #(
  parameter int unsigned DEBOUNCE_CYCLES = 1000,
  parameter int unsigned RESET_HOLD      = 16,
  parameter int unsigned HEX_DIGITS      = 6
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              pll_locked,
  input  logic [board_pkg::NUM_KEYS-1:0]    key,
  output board_pkg::seg_t [HEX_DIGITS-1:0]  hex,
  output logic [4:0]                        led
);

  import board_pkg::*;

  // Debounced key signals
  logic [NUM_KEYS-1:0]   key_level;
  logic [NUM_KEYS-1:0]   key_edge;
  logic [NUM_KEYS-1:0]   key_rise;
  logic [NUM_KEYS-1:0]   key_fall;

  logic                  sys_rst;
  logic                  go;
  logic                  clear;
  bcd_t [HEX_DIGITS-1:0] digits;

  // ========================================
  // One debouncer per key
  // ========================================
  genvar dbc_idx;
  generate
    for (dbc_idx = 0; dbc_idx < NUM_KEYS; dbc_idx++) begin : debouncer_gen_loop
      key_debouncer #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
      ) u_dbc (
        .clk  (clk),
        .rst  (rst),
        .in   (key[dbc_idx]),
        .out  (key_level[dbc_idx]),
        .edj  (key_edge[dbc_idx]),
        .rise (key_rise[dbc_idx]),
        .fall (key_fall[dbc_idx])
      );
    end
  endgenerate

  // Press is a falling level
  assign go    = key_fall[KEY_GO];
  assign clear = key_fall[KEY_CLEAR];

  // ========================================
  // Reset, count and display
  // ========================================
  reset_sequencer #(
    .RESET_HOLD (RESET_HOLD)
  ) u_reset_seq (
    .clk         (clk),
    .rst         (rst),
    .reset_key_n (key_level[KEY_RESET]),
    .pll_locked  (pll_locked),
    .sys_rst     (sys_rst)
  );

  run_counter #(
    .HEX_DIGITS (HEX_DIGITS)
  ) u_run_counter (
    .clk     (clk),
    .sys_rst (sys_rst),
    .go      (go),
    .clear   (clear),
    .digits  (digits)
  );

  hex_display #(
    .HEX_DIGITS (HEX_DIGITS)
  ) u_hex_display (
    .digits (digits),
    .hex    (hex)
  );

  // Status LEDs, 1 means lit
  assign led[0]   = ~sys_rst;
  assign led[4:1] = ~key_level;

endmodule : front_panel_top

`default_nettype wire

//--- dv/front_panel_props.sv
// ========================================
// Debouncer properties, bound to every key_debouncer
// Checked only while rst is low
// ========================================
`timescale 1ns/100ps
`default_nettype none

module front_panel_props (
  input logic clk,
  input logic rst,
  input logic out,
  input logic edj,
  input logic rise,
  input logic fall
);

  // A change has one direction only
  rise_fall_exclusive: assert property (@(posedge clk) disable iff (rst) !(rise && fall))
    else $error("rise and fall are high together");

  edge_is_rise_or_fall: assert property (@(posedge clk) disable iff (rst) edj == (rise || fall))
    else $error("edj differs from rise or fall");

  // Level moves only with its pulse
  level_moves_with_edge: assert property (@(posedge clk) disable iff (rst) !$stable(out) |-> edj)
    else $error("out changed without an edge pulse");

endmodule : front_panel_props

`default_nettype wire

//--- dv/front_panel_checker.sv
// ========================================
// Reference model of the run count and output checks
// Requests are sampled on the rising edge
// DUT outputs are compared on the falling edge
// ========================================
`timescale 1ns/100ps
`default_nettype none

module front_panel_checker #(
  parameter int unsigned HEX_DIGITS = 2
) (
  input  logic                             clk,
  input  logic                             rst,
  input  board_pkg::seg_t [HEX_DIGITS-1:0] hex,
  input  logic [4:0]                       led,
  input  logic                             note_go,
  input  logic                             note_clear,
  input  logic                             note_zero,
  input  logic                             check_req,
  input  logic [4:0]                       exp_led,
  input  logic                             test_end,
  input  int                               test_num,
  input  logic                             tb_fail,
  output int                               check_count,
  output int                               error_count
);

  import board_pkg::*;

  localparam int COUNT_MOD = 10 ** HEX_DIGITS;

  int         model_count = 0;
  int         checks_total = 0;
  int         errors_total = 0;
  int         test_checks = 0;
  int         test_errors = 0;
  int         num_q = 0;
  logic       check_q = 1'b0;
  logic       end_q = 1'b0;
  logic       fail_q = 1'b0;
  logic [4:0] exp_q = '0;

  assign check_count = checks_total;
  assign error_count = errors_total;

  // Segment pattern back to a digit, -1 if unknown
  function automatic int decode_segments(input seg_t pattern);
    for (int i = 0; i < 10; i++) begin
      if (SEG_TABLE[i] == pattern) begin
        return i;
      end
    end
    return -1;
  endfunction

  task automatic compare_outputs();
    int   shown;
    int   weight;
    int   value;
    logic bad_digit;
    shown     = 0;
    weight    = 1;
    bad_digit = 1'b0;
    for (int d = 0; d < HEX_DIGITS; d++) begin
      value = decode_segments(hex[d]);
      if (value < 0) begin
        bad_digit = 1'b1;
      end else begin
        shown = shown + value * weight;
      end
      weight = weight * 10;
    end
    checks_total++;
    test_checks++;
    if (bad_digit || shown != model_count) begin
      $display("** Error at %0t: display shows %0d (segments %h), model count is %0d",
               $time, shown, hex, model_count);
      errors_total++;
      test_errors++;
    end
    if (led != exp_q) begin
      $display("** Error at %0t: led is %b, expected %b", $time, led, exp_q);
      errors_total++;
      test_errors++;
    end
  endtask

  // ========================================
  // Model update, clear wins over go
  // ========================================
  always @(posedge clk) begin
    check_q <= check_req;
    end_q   <= test_end;
    fail_q  <= tb_fail;
    exp_q   <= exp_led;
    num_q   <= test_num;
    if (rst || note_zero || note_clear) begin
      model_count <= 0;
    end else if (note_go) begin
      model_count <= (model_count + 1) % COUNT_MOD;
    end
  end

  always @(negedge clk) begin
    if (check_q) begin
      compare_outputs();
    end
    if (fail_q) begin
      errors_total++;
      test_errors++;
    end
    if (end_q) begin
      $display("Test %0d finished: %0d checks, %0d errors", num_q, test_checks, test_errors);
      test_checks = 0;
      test_errors = 0;
    end
  end

endmodule : front_panel_checker

`default_nettype wire

//--- dv/front_panel_tb.sv
// ========================================
// Testbench for the front-panel top level
// Keys bounce randomly from a fixed seed
// Small parameters so that count wrap is reachable
// ========================================
`timescale 1ns/100ps
`default_nettype none

module front_panel_tb;

  import board_pkg::*;

  localparam int unsigned DEBOUNCE_CYCLES = 8;
  localparam int unsigned RESET_HOLD      = 4;
  localparam int unsigned HEX_DIGITS      = 2;
  localparam int BOUNCE_MAX = 7;
  localparam int TOGGLE_MAX = 6;
  localparam int STABLE_MIN = 40;
  localparam int RUN_WAIT   = 200;
  // Press plus release, each with bounce and stable time
  localparam int PRESS_CYCLES   = 2 * (TOGGLE_MAX * BOUNCE_MAX + STABLE_MIN + 16) + 4;
  localparam int TIMEOUT_CYCLES = 6 * 110 * PRESS_CYCLES;
  localparam int EV_GO    = 0;
  localparam int EV_CLEAR = 1;
  localparam int EV_ZERO  = 2;
  localparam int EV_FAIL  = 3;

  logic                  clk = 1'b0;
  logic                  rst;
  logic                  pll_locked;
  logic [NUM_KEYS-1:0]   key;
  seg_t [HEX_DIGITS-1:0] hex;
  logic [4:0]            led;
  logic                  note_go = 1'b0;
  logic                  note_clear = 1'b0;
  logic                  note_zero = 1'b0;
  logic                  tb_fail = 1'b0;
  logic                  check_req = 1'b0;
  logic                  test_end = 1'b0;
  logic [4:0]            exp_led = '0;
  int                    test_num = 0;
  int                    check_count;
  int                    error_count;
  int                    cycle_count = 0;
  integer                seed = 32'hf948;

  always #2 clk = ~clk;

  front_panel_top #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES),
    .RESET_HOLD      (RESET_HOLD),
    .HEX_DIGITS      (HEX_DIGITS)
  ) dut (
    .clk        (clk),
    .rst        (rst),
    .pll_locked (pll_locked),
    .key        (key),
    .hex        (hex),
    .led        (led)
  );

  front_panel_checker #(
    .HEX_DIGITS (HEX_DIGITS)
  ) u_checker (
    .clk         (clk),
    .rst         (rst),
    .hex         (hex),
    .led         (led),
    .note_go     (note_go),
    .note_clear  (note_clear),
    .note_zero   (note_zero),
    .check_req   (check_req),
    .exp_led     (exp_led),
    .test_end    (test_end),
    .test_num    (test_num),
    .tb_fail     (tb_fail),
    .check_count (check_count),
    .error_count (error_count)
  );

  bind key_debouncer front_panel_props u_props (
    .clk  (clk),
    .rst  (rst),
    .out  (out),
    .edj  (edj),
    .rise (rise),
    .fall (fall)
  );

  function automatic int rand_range(input int lo, input int hi);
    int unsigned r;
    r = $unsigned($random(seed));
    return lo + int'(r % (hi - lo + 1));
  endfunction

  // Bounce burst ending in a stable level, no bounce segment reaches 8 cycles
  task automatic bounce_to(input int idx, input logic level, input int min_stable);
    int toggles;
    toggles = rand_range(2, TOGGLE_MAX);
    for (int t = 0; t < toggles; t++) begin
      key[idx] = (t % 2 == 0) ? level : ~level;
      repeat (rand_range(1, BOUNCE_MAX)) @(negedge clk);
    end
    key[idx] = level;
    repeat (min_stable + rand_range(0, 15)) @(negedge clk);
  endtask

  task automatic pulse_note(input int kind);
    case (kind)
      EV_GO:    note_go = 1'b1;
      EV_CLEAR: note_clear = 1'b1;
      EV_ZERO:  note_zero = 1'b1;
      default:  tb_fail = 1'b1;
    endcase
    @(negedge clk);
    note_go    = 1'b0;
    note_clear = 1'b0;
    note_zero  = 1'b0;
    tb_fail    = 1'b0;
  endtask

  task automatic key_press(input int idx, input int kind);
    bounce_to(idx, 1'b0, STABLE_MIN);
    pulse_note(kind);
    bounce_to(idx, 1'b1, STABLE_MIN);
  endtask

  task automatic check_now(input logic [4:0] expected);
    exp_led   = expected;
    check_req = 1'b1;
    @(negedge clk);
    check_req = 1'b0;
  endtask

  task automatic end_test();
    test_end = 1'b1;
    @(negedge clk);
    test_end = 1'b0;
  endtask

  task automatic wait_run();
    int waited;
    waited = 0;
    while (!led[0] && waited < RUN_WAIT) begin
      @(negedge clk);
      waited++;
    end
    if (!led[0]) begin
      $display("Test %0d: system reset still active after %0d cycles", test_num, RUN_WAIT);
      pulse_note(EV_FAIL);
    end
  endtask

  // Run limit
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count == TIMEOUT_CYCLES) begin
      $display("Timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
      $display("Checks failed");
      $finish;
    end
  end

  // ========================================
  // Test sequence
  // ========================================
  initial begin
    rst        = 1'b1;
    pll_locked = 1'b1;
    key        = '1;
    repeat (10) @(negedge clk);
    rst = 1'b0;

    test_num = 1;
    wait_run();
    check_now(5'b00001);
    end_test();

    // Bursts only, never stable for long enough
    test_num = 2;
    repeat (5) bounce_to(KEY_GO, 1'b1, 20);
    check_now(5'b00001);
    end_test();

    test_num = 3;
    repeat (rand_range(1, 20)) key_press(KEY_GO, EV_GO);
    check_now(5'b00001);
    end_test();

    test_num = 4;
    bounce_to(KEY_CLEAR, 1'b0, STABLE_MIN);
    pulse_note(EV_CLEAR);
    check_now(5'b00101);
    bounce_to(KEY_CLEAR, 1'b1, STABLE_MIN);
    repeat (rand_range(1, 10)) key_press(KEY_GO, EV_GO);
    check_now(5'b00001);
    end_test();

    test_num = 5;
    key_press(KEY_CLEAR, EV_CLEAR);
    repeat (105) key_press(KEY_GO, EV_GO);
    check_now(5'b00001);
    end_test();

    // Lock drop, then the reset key
    test_num = 6;
    pll_locked = 1'b0;
    repeat (10) @(negedge clk);
    pulse_note(EV_ZERO);
    check_now(5'b00000);
    pll_locked = 1'b1;
    wait_run();
    repeat (3) key_press(KEY_GO, EV_GO);
    check_now(5'b00001);
    bounce_to(KEY_RESET, 1'b0, STABLE_MIN);
    pulse_note(EV_ZERO);
    check_now(5'b10000);
    bounce_to(KEY_RESET, 1'b1, STABLE_MIN);
    wait_run();
    repeat (2) key_press(KEY_GO, EV_GO);
    check_now(5'b00001);
    end_test();

    repeat (4) @(posedge clk);
    $display("Summary: 6 tests, %0d checks, %0d errors", check_count, error_count);
    if (error_count == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule : front_panel_tb

`default_nettype wire

//--- vlog.f
logic/board_pkg.sv
logic/key_debouncer.sv
logic/reset_sequencer.sv
logic/run_counter.sv
logic/hex_display.sv
logic/front_panel_top.sv
dv/front_panel_props.sv
dv/front_panel_checker.sv
dv/front_panel_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the front-panel testbench with Verilator
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert --top-module front_panel_tb -f vlog.f \
  -o front_panel_sim > build.log 2>&1 || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/front_panel_sim > "$log" 2>&1 || echo "Simulator exited with an error" >> "$log"
cat "$log"

grep -q "Checks failed" "$log" && { echo "FAIL"; exit 1; }
grep -q "All checks passed" "$log" || { echo "FAIL: run did not complete"; exit 1; }
echo "PASS"
